//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert --timescale 1ns/1ps
TOP       := match_stage_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+src
src/match_cfg_pkg.sv
src/match_data_pkg.sv
src/lookup_if.sv
src/key_extractor.sv
src/tcam_table.sv
src/lmt_result_stage.sv
src/match_stage_top.sv
tests/match_stage_assertions.sv
tests/match_stage_tb.sv

//--- src/key_extractor.sv
`include "match_defines.svh"

// Cuts one fixed header field out of the PHV, one register stage
module key_extractor
    import match_cfg_pkg::*;
    import match_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  field_sel_t field_sel,
    input  logic       phv_valid,
    input  phv_t       phv,
    output logic       key_valid,
    output match_key_t key
);

    // ==================================================
    // Valid strobe
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_valid <= 1'b0;
        end else begin
            key_valid <= phv_valid;
        end
    end

    // ==================================================
    // Field select, zero extended into the key
    // ==================================================
    always_ff @(posedge clk) begin
        if (!phv_valid) begin
            key <= '0;                                 // Idle key stays clean
        end else begin
            case (field_sel)
                4'd0:    key <= match_key_t'(phv[47:0]);    // Source MAC
                4'd1:    key <= match_key_t'(phv[95:48]);   // Dest MAC
                4'd2:    key <= match_key_t'(phv[111:96]);  // VLAN tag
                4'd3:    key <= match_key_t'(phv[143:112]); // Source IPv4
                4'd4:    key <= match_key_t'(phv[175:144]); // Dest IPv4
                4'd5:    key <= match_key_t'(phv[191:176]); // Source port
                4'd6:    key <= match_key_t'(phv[207:192]); // Dest port
                4'd7:    key <= match_key_t'(phv[215:208]); // IP protocol
                default: key <= '0;                         // Unmapped selector
            endcase
        end
    end

endmodule

//--- src/lmt_result_stage.sv
// LMT config, search issue and UMT cascade merge
module lmt_result_stage
    import match_cfg_pkg::*;
    import match_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cfg_wr_en,
    input  logic         cfg_used,
    input  umt_id_t      cfg_uid,
    input  cascade_pos_e cfg_pos,
    input  logic         entry_wr_en,
    output logic         tbl_wr_en,
    input  logic         req_valid,
    input  match_key_t   req_key,
    input  umt_id_t      req_umt_id,
    input  logic         req_prev_found,
    input  entry_addr_t  req_prev_addr,
    input  metadata_t    req_prev_meta,
    lookup_if.requester  lookup,
    output logic         result_valid,
    output umt_id_t      result_umt_id,
    output logic         result_found,
    output entry_addr_t  result_addr,
    output metadata_t    result_metadata
);

    // ==================================================
    // Config registers
    // ==================================================
    logic         used_q;
    umt_id_t      uid_q;
    cascade_pos_e pos_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used_q <= 1'b0;            // LMT off after reset
            uid_q  <= '0;
            pos_q  <= CASCADE_SINGLE;
        end else if (cfg_wr_en) begin
            used_q <= cfg_used;
            uid_q  <= cfg_uid;
            pos_q  <= cfg_pos;
        end
    end

    assign tbl_wr_en = entry_wr_en && used_q; // Unused LMT ignores writes

    // Issue decision
    logic umt_match, not_end, skip, do_search;

    assign umt_match = used_q && (req_umt_id == uid_q);
    assign not_end   = (pos_q != CASCADE_END);
    assign skip      = req_prev_found && umt_match && not_end; // Earlier LMT already won
    assign do_search = req_valid && umt_match && !skip;

    assign lookup.search_en  = do_search;
    assign lookup.search_key = req_key;

    // ==================================================
    // s1, request travels beside the table lookup
    // ==================================================
    logic        valid_s1, prev_found_s1, skip_s1;
    umt_id_t     umt_id_s1;
    entry_addr_t prev_addr_s1;
    metadata_t   prev_meta_s1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1      <= 1'b0;
            prev_found_s1 <= 1'b0;
            skip_s1       <= 1'b0;
        end else begin
            valid_s1      <= req_valid;
            prev_found_s1 <= req_prev_found;
            skip_s1       <= skip;
        end
    end

    always_ff @(posedge clk) begin
        umt_id_s1    <= req_umt_id;
        prev_addr_s1 <= req_prev_addr;
        prev_meta_s1 <= req_prev_meta;
    end

    // Cascade merge
    logic        found_m;
    entry_addr_t addr_m;
    metadata_t   meta_m;

    always_comb begin
        if (skip_s1 || (prev_found_s1 && not_end)) begin
            found_m = prev_found_s1;   // Pass previous result on
            addr_m  = prev_addr_s1;
            meta_m  = prev_meta_s1;
        end else if (lookup.hit) begin
            found_m = 1'b1;            // Own hit
            addr_m  = lookup.hit_addr;
            meta_m  = lookup.hit_action;
        end else begin
            found_m = 1'b0;
            addr_m  = '0;
            meta_m  = '0;
        end
    end

    // ==================================================
    // s2 and output register
    // ==================================================
    logic        valid_s2, found_s2;
    umt_id_t     umt_id_s2;
    entry_addr_t addr_s2;
    metadata_t   meta_s2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s2  <= 1'b0;
            umt_id_s2 <= '0;
            found_s2  <= 1'b0;
            addr_s2   <= '0;
            meta_s2   <= '0;
        end else begin
            valid_s2  <= valid_s1;
            umt_id_s2 <= umt_id_s1;
            found_s2  <= found_m;
            addr_s2   <= addr_m;
            meta_s2   <= meta_m;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid    <= 1'b0;
            result_umt_id   <= '0;
            result_found    <= 1'b0;
            result_addr     <= '0;
            result_metadata <= '0;
        end else begin
            result_valid    <= valid_s2;
            result_umt_id   <= umt_id_s2;
            result_found    <= found_s2;
            result_addr     <= addr_s2;
            result_metadata <= meta_s2;
        end
    end

endmodule

//--- src/lookup_if.sv
// Search request and registered result between LMT and its TCAM
interface lookup_if
    import match_data_pkg::*;
();

    logic        search_en;   // Level, issue cycle only
    match_key_t  search_key;
    logic        hit;         // One cycle after search_en
    entry_addr_t hit_addr;    // Lowest matching entry
    metadata_t   hit_action;

    // LMT side
    modport requester (
        output search_en, search_key,
        input  hit, hit_addr, hit_action
    );

    // Table side
    modport tbl (
        input  search_en, search_key,
        output hit, hit_addr, hit_action
    );

endinterface

//--- src/match_cfg_pkg.sv
`include "match_defines.svh"

// Table configuration types
package match_cfg_pkg;

    // Id of the unified match table an LMT belongs to
    typedef logic [`MATCH_UMT_W-1:0] umt_id_t;

    // Which header field feeds the key
    typedef logic [`MATCH_FIELD_W-1:0] field_sel_t;

    // Position of this LMT inside its UMT cascade
    typedef enum logic [1:0] {
        CASCADE_SINGLE = 2'b00, // Whole UMT in one LMT
        CASCADE_START  = 2'b01,
        CASCADE_MIDDLE = 2'b10,
        CASCADE_END    = 2'b11  // Last one, own hit still counts
    } cascade_pos_e;

endpackage

//--- src/match_data_pkg.sv
`include "match_defines.svh"

// Types of the data moving down the pipeline
package match_data_pkg;

    // Raw header vector from the parser
    typedef logic [`MATCH_PHV_W-1:0] phv_t;

    // Search key, also used for entry key and care mask
    typedef logic [`MATCH_KEY_W-1:0] match_key_t;

    // Table entry address
    typedef logic [`MATCH_ADDR_W-1:0] entry_addr_t;

    // Action data returned on a hit
    typedef logic [`MATCH_META_W-1:0] metadata_t;

endpackage

//--- src/match_defines.svh
`ifndef MATCH_DEFINES_SVH
`define MATCH_DEFINES_SVH

// ==================================================
// Match stage widths and depths
// ==================================================

`define MATCH_PHV_W    256  // Packet header vector
`define MATCH_KEY_W    64   // Search key, entry key and care mask
`define MATCH_DEPTH    16   // Table entries
`define MATCH_ADDR_W   4    // log2 of depth
`define MATCH_META_W   64   // Action data per entry

// Config fields
`define MATCH_UMT_W    8    // UMT id
`define MATCH_FIELD_W  4    // Header field selector

`endif

//--- src/match_stage_top.sv
// One match stage: extractor, LMT result logic and local TCAM
module match_stage_top
    import match_cfg_pkg::*;
    import match_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cfg_wr_en,
    input  logic         cfg_used,
    input  umt_id_t      cfg_uid,
    input  cascade_pos_e cfg_pos,
    input  logic         entry_wr_en,
    input  entry_addr_t  entry_wr_addr,
    input  match_key_t   entry_wr_data,
    input  match_key_t   entry_wr_mask,
    input  metadata_t    entry_wr_action,
    input  field_sel_t   field_sel,
    input  logic         phv_valid,
    input  phv_t         phv,
    input  umt_id_t      umt_id_in,
    input  logic         prev_found,
    input  entry_addr_t  prev_addr,
    input  metadata_t    prev_metadata,
    output logic         result_valid,
    output umt_id_t      result_umt_id,
    output logic         result_found,
    output entry_addr_t  result_addr,
    output metadata_t    result_metadata
);

    logic        key_valid;
    match_key_t  key;
    logic        tbl_wr_en;

    // ==================================================
    // Align request side data with the extracted key
    // ==================================================
    logic        prev_found_d;
    umt_id_t     umt_id_d;
    entry_addr_t prev_addr_d;
    metadata_t   prev_meta_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_found_d <= 1'b0;
        end else begin
            prev_found_d <= prev_found;
        end
    end

    always_ff @(posedge clk) begin
        umt_id_d    <= umt_id_in;
        prev_addr_d <= prev_addr;
        prev_meta_d <= prev_metadata;
    end

    lookup_if lookup_bus ();                   // LMT to TCAM

    key_extractor u_key_extractor (
        .clk       (clk),
        .rst_n     (rst_n),
        .field_sel (field_sel),
        .phv_valid (phv_valid),
        .phv       (phv),
        .key_valid (key_valid),
        .key       (key)
    );

    lmt_result_stage u_lmt_result (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_wr_en       (cfg_wr_en),
        .cfg_used        (cfg_used),
        .cfg_uid         (cfg_uid),
        .cfg_pos         (cfg_pos),
        .entry_wr_en     (entry_wr_en),
        .tbl_wr_en       (tbl_wr_en),
        .req_valid       (key_valid),
        .req_key         (key),
        .req_umt_id      (umt_id_d),
        .req_prev_found  (prev_found_d),
        .req_prev_addr   (prev_addr_d),
        .req_prev_meta   (prev_meta_d),
        .lookup          (lookup_bus.requester),
        .result_valid    (result_valid),
        .result_umt_id   (result_umt_id),
        .result_found    (result_found),
        .result_addr     (result_addr),
        .result_metadata (result_metadata)
    );

    tcam_table u_tcam (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (tbl_wr_en),              // Gated write
        .wr_addr   (entry_wr_addr),
        .wr_key    (entry_wr_data),
        .wr_mask   (entry_wr_mask),
        .wr_action (entry_wr_action),
        .lookup    (lookup_bus.tbl)
    );

endmodule

//--- src/tcam_table.sv
`include "match_defines.svh"

// Local ternary table, parallel compare, lowest address wins
module tcam_table
    import match_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,     // Already gated by used flag
    input  entry_addr_t wr_addr,
    input  match_key_t  wr_key,
    input  match_key_t  wr_mask,   // 1 = bit must match
    input  metadata_t   wr_action,
    lookup_if.tbl       lookup
);

    // ==================================================
    // Entry storage
    // ==================================================
    logic [`MATCH_DEPTH-1:0] entry_valid;
    match_key_t              entry_key    [`MATCH_DEPTH];
    match_key_t              entry_mask   [`MATCH_DEPTH];
    metadata_t               entry_action [`MATCH_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;                 // Empty table
        end else if (wr_en) begin
            entry_valid[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_key[wr_addr]    <= wr_key;
            entry_mask[wr_addr]   <= wr_mask;
            entry_action[wr_addr] <= wr_action;
        end
    end

    // ==================================================
    // Compare and priority
    // ==================================================
    logic [`MATCH_DEPTH-1:0] match_vec;  // One line per entry
    logic                    any_match;
    logic                    hit_now;
    entry_addr_t             win_addr;

    // Cared bits only
    always_comb begin
        for (int i = 0; i < `MATCH_DEPTH; i++) begin
            match_vec[i] = entry_valid[i] &&
                (((entry_key[i] ^ lookup.search_key) & entry_mask[i]) == '0);
        end
    end

    // Scan downward so the lowest hit is written last
    always_comb begin
        win_addr = '0;
        for (int i = `MATCH_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                win_addr = entry_addr_t'(i);
            end
        end
    end

    assign any_match = |match_vec;
    assign hit_now   = lookup.search_en && any_match;

    // Result register, one cycle after issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup.hit <= 1'b0;
        end else begin
            lookup.hit <= hit_now;               // Low when nothing was searched
        end
    end

    always_ff @(posedge clk) begin
        lookup.hit_addr   <= hit_now ? win_addr : '0;
        lookup.hit_action <= hit_now ? entry_action[win_addr] : '0;
    end

endmodule

//--- tests/match_stage_assertions.sv
module match_stage_assertions
    import match_data_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        phv_valid,
    input logic        result_valid,
    input logic        result_found,
    input entry_addr_t result_addr,
    input metadata_t   result_metadata
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Read back by the testbench

    // ==================================================
    // Timing and result shape
    // ==================================================
    // Fixed four cycle pipeline
    latency_chk: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(phv_valid, 4))
        else begin
            fail_count++;
            $error("result_valid does not follow phv_valid by four cycles");
        end

    // No match carries no address or action
    miss_zero_chk: assert property (@(posedge clk) disable iff (!rst_n)
        !result_found |-> (result_addr == '0 && result_metadata == '0))
        else begin
            fail_count++;
            $error("result_found low with nonzero address or metadata");
        end

    reset_quiet_chk: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else begin
            fail_count++;
            $error("result_valid high during reset");
        end

endmodule

bind match_stage_top match_stage_assertions u_assertions (
    .clk             (clk),
    .rst_n           (rst_n),
    .phv_valid       (phv_valid),
    .result_valid    (result_valid),
    .result_found    (result_found),
    .result_addr     (result_addr),
    .result_metadata (result_metadata)
);

//--- tests/match_stage_tb.sv
`include "match_defines.svh"

module match_stage_tb
    import match_cfg_pkg::*;
    import match_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // Run limits
    // ==================================================
    localparam int NUM_TESTS      = 6;
    localparam int LONGEST_CYCLES = 100;  // Field test has 8 writes plus 11 lookups
    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 8;
    localparam int WATCHDOG_NS    = (NUM_TESTS * LONGEST_CYCLES + RESET_CYCLES) * CLK_PERIOD;
    localparam int LATENCY        = 4;   // phv_valid edge to result_valid edge

    // Field map as offset and width with field 0 rightmost
    localparam logic [7:0][7:0] FIELD_LO = {8'd208, 8'd192, 8'd176, 8'd144,
                                            8'd112, 8'd96, 8'd48, 8'd0};
    localparam logic [7:0][7:0] FIELD_W  = {8'd8, 8'd16, 8'd16, 8'd32,
                                            8'd32, 8'd16, 8'd48, 8'd48};

    logic         clk;
    logic         rst_n;
    logic         cfg_wr_en;
    logic         cfg_used;
    umt_id_t      cfg_uid;
    cascade_pos_e cfg_pos;
    logic         entry_wr_en;
    entry_addr_t  entry_wr_addr;
    match_key_t   entry_wr_data;
    match_key_t   entry_wr_mask;
    metadata_t    entry_wr_action;
    field_sel_t   field_sel;
    logic         phv_valid;
    phv_t         phv;
    umt_id_t      umt_id_in;
    logic         prev_found;
    entry_addr_t  prev_addr;
    metadata_t    prev_metadata;
    logic         result_valid;
    umt_id_t      result_umt_id;
    logic         result_found;
    entry_addr_t  result_addr;
    metadata_t    result_metadata;

    typedef struct packed {
        field_sel_t  sel;
        phv_t        phv;
        umt_id_t     umt;
        logic        pf;    // Previous stage found
        entry_addr_t pa;
        metadata_t   pm;
    } req_t;

    typedef struct packed {
        logic        found;
        entry_addr_t addr;
        metadata_t   meta;
        umt_id_t     umt;
    } res_t;

    req_t pending  [$];   // Requests waiting for the next burst
    res_t expected [$];   // In flight with oldest first

    // Reference copy of config and table
    logic                    m_used;
    umt_id_t                 m_uid;
    cascade_pos_e            m_pos;
    logic [`MATCH_DEPTH-1:0] m_valid;
    match_key_t              m_key  [`MATCH_DEPTH];
    match_key_t              m_mask [`MATCH_DEPTH];
    metadata_t               m_act  [`MATCH_DEPTH];

    logic [15:0] lfsr_q;
    int          errors;
    int          tests_failed;
    int          test_err_base;
    phv_t        p_fields;        // Header behind the field entries
    phv_t        p_prio;          // Header behind the priority pair

    match_stage_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==================================================
    // Stimulus helpers
    // ==================================================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);      // One step per bit
            v      = {v[62:0], lfsr_q[0]};
        end
    endtask

    task automatic random_phv(output phv_t p);
        logic [63:0] w;
        for (int i = 0; i < 4; i++) begin
            take_bits(64, w);
            p[i*64 +: 64] = w;
        end
    endtask

    function automatic match_key_t field_key(input field_sel_t sel, input phv_t p);
        phv_t cut;
        if (sel > 4'd7) begin
            return '0;                       // Unmapped selector
        end
        cut = (p >> FIELD_LO[sel[2:0]]) & ((phv_t'(1) << FIELD_W[sel[2:0]]) - phv_t'(1));
        return match_key_t'(cut);            // Zero extended
    endfunction

    // Cascade rule then lowest matching address
    function automatic res_t predict(input req_t r);
        res_t       e;
        match_key_t k;
        k     = field_key(r.sel, r.phv);
        e     = '0;
        e.umt = r.umt;
        if (r.pf && (m_pos != CASCADE_END)) begin
            e.found = 1'b1;                  // Pass through
            e.addr  = r.pa;
            e.meta  = r.pm;
        end else if (m_used && (r.umt == m_uid)) begin
            for (int i = 0; i < `MATCH_DEPTH; i++) begin
                if (!e.found && m_valid[i] && ((m_key[i] & m_mask[i]) == (k & m_mask[i]))) begin
                    e.found = 1'b1;
                    e.addr  = entry_addr_t'(i);
                    e.meta  = m_act[i];
                end
            end
        end
        return e;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic check_found(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0b expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input entry_addr_t got, input entry_addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_meta(input metadata_t got, input metadata_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_umt(input umt_id_t got, input umt_id_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // ==================================================
    // Bus tasks
    // ==================================================
    task automatic write_cfg(input logic used, input umt_id_t uid, input cascade_pos_e pos);
        @(posedge clk);
        cfg_wr_en <= 1'b1;
        cfg_used  <= used;
        cfg_uid   <= uid;
        cfg_pos   <= pos;
        @(posedge clk);
        cfg_wr_en <= 1'b0;
        m_used = used;
        m_uid  = uid;
        m_pos  = pos;
    endtask

    task automatic write_entry(input entry_addr_t a, input match_key_t k, input match_key_t m,
                               input metadata_t act);
        @(posedge clk);
        entry_wr_en     <= 1'b1;
        entry_wr_addr   <= a;
        entry_wr_data   <= k;
        entry_wr_mask   <= m;
        entry_wr_action <= act;
        @(posedge clk);
        entry_wr_en <= 1'b0;
        if (m_used) begin                    // Unused LMT drops writes
            m_valid[a] = 1'b1;
            m_key[a]   = k;
            m_mask[a]  = m;
            m_act[a]   = act;
        end
    endtask

    task automatic add_req(input field_sel_t sel, input phv_t p, input umt_id_t u,
                           input logic pf, input entry_addr_t pa, input metadata_t pm);
        pending.push_back(req_t'({sel, p, u, pf, pa, pm}));
    endtask

    // Drives all pending requests back to back and checks each result
    task automatic run_batch();
        int   n;
        int   lat;
        req_t r;
        res_t e_drv;
        res_t e_chk;
        n = pending.size();
        @(posedge clk);
        fork
            begin
                for (int i = 0; i < n; i++) begin
                    r     = pending.pop_front();
                    e_drv = predict(r);
                    expected.push_back(e_drv);
                    phv_valid     <= 1'b1;
                    field_sel     <= r.sel;
                    phv           <= r.phv;
                    umt_id_in     <= r.umt;     // Same edge as the header
                    prev_found    <= r.pf;
                    prev_addr     <= r.pa;
                    prev_metadata <= r.pm;
                    @(posedge clk);
                end
                phv_valid <= 1'b0;
            end
            begin
                lat = 0;
                do begin
                    @(posedge clk);
                    lat++;
                    @(negedge clk);              // Sample away from the edge
                end while (!result_valid && lat < 3 * LATENCY);
                if (!result_valid) begin
                    $display("No result_valid within %0d cycles of a request", lat);
                    errors++;
                end else begin
                    if (lat != LATENCY) begin
                        $display("FAILED at %0t: latency %0d cycles expected %0d",
                                 $time, lat, LATENCY);
                        errors++;
                    end
                    for (int i = 0; i < n; i++) begin
                        if (i > 0) begin
                            @(negedge clk);
                            check_found(result_valid, 1'b1, "result_valid in burst");
                        end
                        e_chk = expected.pop_front();
                        check_found(result_found, e_chk.found, "result_found");
                        check_addr(result_addr, e_chk.addr, "result_addr");
                        check_meta(result_metadata, e_chk.meta, "result_metadata");
                        check_umt(result_umt_id, e_chk.umt, "result_umt_id");
                    end
                end
            end
        join
        expected.delete();
    endtask

    task automatic end_test(input string name);
        if (errors == test_err_base) begin
            $display("%-14s ok", name);
        end else begin
            $display("%-14s %0d errors", name, errors - test_err_base);
            tests_failed++;
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_empty();
        phv_t p;
        test_err_base = errors;
        @(negedge clk);
        check_found(result_valid, 1'b0, "result_valid after reset");
        write_cfg(1'b1, 8'h21, CASCADE_SINGLE);
        random_phv(p);
        add_req(4'd0, p, 8'h21, 1'b0, '0, '0);
        add_req(4'd4, p, 8'h21, 1'b0, '0, '0);
        run_batch();
        end_test("reset_empty");
    endtask

    task automatic test_fields();
        match_key_t  mask;
        logic [63:0] act;
        phv_t        other;
        test_err_base = errors;
        random_phv(p_fields);
        for (int s = 0; s < 8; s++) begin
            mask = (s[0] && s < 7) ? ~match_key_t'(8'hFF) : '1;  // Low byte don't care
            take_bits(64, act);
            write_entry(entry_addr_t'(s + 2),
                        field_key(field_sel_t'(s), p_fields) ^ (~mask & match_key_t'(8'h5A)),
                        mask, act);
        end
        for (int s = 0; s < 9; s++) begin
            add_req(field_sel_t'(s), p_fields, 8'h21, 1'b0, '0, '0);
        end
        add_req(4'd12, p_fields, 8'h21, 1'b0, '0, '0);     // Zero key
        random_phv(other);
        add_req(4'd3, other, 8'h21, 1'b0, '0, '0);
        run_batch();
        end_test("fields");
    endtask

    task automatic test_priority();
        match_key_t  k;
        logic [63:0] act;
        test_err_base = errors;
        random_phv(p_prio);
        k = field_key(4'd4, p_prio);
        take_bits(64, act);
        write_entry(4'd14, k, '1, act);
        take_bits(64, act);
        write_entry(4'd11, k ^ 64'h3, ~match_key_t'(4'hF), act);  // Looser entry at lower address
        add_req(4'd4, p_prio, 8'h21, 1'b0, '0, '0);
        run_batch();
        end_test("priority");
    endtask

    task automatic test_cascade();
        logic [63:0] pm;
        test_err_base = errors;
        take_bits(64, pm);
        write_cfg(1'b1, 8'h21, CASCADE_START);
        add_req(4'd4, p_prio, 8'h21, 1'b1, 4'hA, pm);   // Skipped
        add_req(4'd4, p_prio, 8'h21, 1'b0, 4'hA, pm);   // Own hit
        run_batch();
        write_cfg(1'b1, 8'h21, CASCADE_MIDDLE);
        add_req(4'd4, p_prio, 8'h21, 1'b1, 4'h3, pm);
        run_batch();
        write_cfg(1'b1, 8'h21, CASCADE_END);
        add_req(4'd4, p_prio, 8'h21, 1'b1, 4'hA, pm);   // Own hit decides
        add_req(4'd12, p_prio, 8'h21, 1'b1, 4'hA, pm);  // Own miss at end
        run_batch();
        end_test("cascade");
    endtask

    task automatic test_gating();
        phv_t        p;
        logic [63:0] act;
        test_err_base = errors;
        write_cfg(1'b0, 8'h21, CASCADE_SINGLE);
        random_phv(p);
        take_bits(64, act);
        write_entry(4'd0, field_key(4'd2, p), '1, act); // Dropped
        add_req(4'd4, p_prio, 8'h21, 1'b0, '0, '0);    // Not searched
        add_req(4'd4, p_prio, 8'h21, 1'b1, 4'h5, act);
        run_batch();
        write_cfg(1'b1, 8'h21, CASCADE_SINGLE);
        add_req(4'd2, p, 8'h21, 1'b0, '0, '0);
        add_req(4'd4, p_prio, 8'h33, 1'b0, '0, '0);    // Other UMT
        run_batch();
        end_test("gating");
    endtask

    task automatic test_stream();
        logic [63:0] b;
        phv_t        p;
        umt_id_t     u;
        test_err_base = errors;
        for (int i = 0; i < 12; i++) begin
            take_bits(1, b);
            if (b[0]) begin
                p = p_fields;                // Known entries
            end else begin
                random_phv(p);
            end
            take_bits(1, b);
            u = b[0] ? 8'h22 : 8'h21;
            take_bits(3, b);
            add_req(field_sel_t'(b[2:0]), p, u, 1'b0, '0, '0);
        end
        run_batch();
        end_test("stream");
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================
    initial begin
        clk             = 1'b0;
        rst_n           <= 1'b0;
        cfg_wr_en       <= 1'b0;
        cfg_used        <= 1'b0;
        cfg_uid         <= '0;
        cfg_pos         <= CASCADE_SINGLE;
        entry_wr_en     <= 1'b0;
        entry_wr_addr   <= '0;
        entry_wr_data   <= '0;
        entry_wr_mask   <= '0;
        entry_wr_action <= '0;
        field_sel       <= '0;
        phv_valid       <= 1'b0;
        phv             <= '0;
        umt_id_in       <= '0;
        prev_found      <= 1'b0;
        prev_addr       <= '0;
        prev_metadata   <= '0;
        lfsr_q          = 16'd60;
        errors          = 0;
        tests_failed    = 0;
        m_used          = 1'b0;
        m_uid           = '0;
        m_pos           = CASCADE_SINGLE;
        m_valid         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_empty();
        test_fields();
        test_priority();
        test_cascade();
        test_gating();
        test_stream();
        if (DUT.u_assertions.fail_count != 0) begin
            $display("Bound checker saw %0d assertion failures", DUT.u_assertions.fail_count);
            errors += DUT.u_assertions.fail_count;
        end
        $display("Tests %0d, failing tests %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule
